//--- project.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/decodeExecIf.sv
hdl/regFile.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/cpuCore.sv
verification/cpuCore_assertions.sv
verification/cpuCoreTb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - hdl/isaPkg.sv
  - hdl/pipePkg.sv
  - hdl/decodeExecIf.sv
  - hdl/regFile.sv
  - hdl/fetchStage.sv
  - hdl/decodeStage.sv
  - hdl/executeStage.sv
  - hdl/cpuCore.sv
  - target: test
    files:
      - verification/cpuCore_assertions.sv
      - verification/cpuCoreTb.sv

//--- verification/cpuCoreTb.sv
// **************************************************************************
// testbench for the three-stage core, runs a fixed program from a ROM
// checks every retire against an ISA reference model under random credits
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

	import isaPkg::*;

	localparam int RetireCredits = 4;
	localparam int RomWords      = 64;
	localparam int MaxRetires    = 64;
	localparam int ModelSteps    = 256;
	localparam int HaltTimeout   = 4000;
	localparam int QuietCycles   = 20;

	logic        clk;
	logic        rstN;
	logic        creditReturn;
	instrT       imemData;
	pcT          imemAddr;
	logic        retireValid;
	regIdxT      retireReg;
	dataT        retireData;
	pcT          retirePc;
	logic        halted;

	instrT       rom [RomWords];
	regIdxT      expReg [MaxRetires];
	dataT        expData [MaxRetires];
	pcT          expPc [MaxRetires];
	int          expCount;
	int          retireIdx;
	int          outstanding;
	int          waitCycles;
	logic [31:0] lfsr;
	logic [15:0] creditPick;
	pcT          haltAddr;

	cpuCore #(
		.RetireCredits (RetireCredits)
	) dut_i (
		.clk          (clk),
		.rstN         (rstN),
		.imemData     (imemData),
		.creditReturn (creditReturn),
		.imemAddr     (imemAddr),
		.retireValid  (retireValid),
		.retireReg    (retireReg),
		.retireData   (retireData),
		.retirePc     (retirePc),
		.halted       (halted)
	);

	// instruction memory, word index from the byte address
	assign imemData = rom[imemAddr[6:1]];

	always begin
		clk = 1'b0;
		#50;
		clk = 1'b1;
		#50;
	end

	// Galois LFSR, taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[14:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
		return v;
	endfunction

	// instruction encoders, one per format
	function automatic instrT encodeImm5(opcodeT op, regIdxT rs, regIdxT rd, logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic instrT encodeAlu(regIdxT rs, regIdxT rt, regIdxT rd, funcT f);
		return {opAlu, rs, rt, rd, f};
	endfunction

	function automatic instrT encodeImm8(opcodeT op, regIdxT rs, logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic instrT encodeJump(opcodeT op, logic [10:0] disp);
		return {op, disp};
	endfunction

	task automatic buildProgram();
		// unused words are NOPs tagged with their own index
		for (int i = 0; i < RomWords; i++) begin
			rom[i] = {opNop, 11'(i)};
		end
		// dependent ALU chain, each op uses the previous result
		rom[0]  = encodeImm8(opLbi, 3'd1, 8'(takeBits(8)));
		rom[1]  = encodeImm8(opLbi, 3'd2, 8'(takeBits(8)));
		rom[2]  = encodeAlu(3'd1, 3'd2, 3'd3, funcAdd);
		rom[3]  = encodeAlu(3'd3, 3'd1, 3'd4, funcSub);
		rom[4]  = encodeImm5(opAddi, 3'd4, 3'd5, 5'(takeBits(5)));
		rom[5]  = encodeAlu(3'd5, 3'd3, 3'd6, funcXor);
		rom[6]  = encodeAlu(3'd6, 3'd5, 3'd1, funcAnd);
		rom[7]  = encodeAlu(3'd1, 3'd1, 3'd2, funcXor);
		// R2 is zero, BEQZ taken over word 9, BNEZ falls through
		rom[8]  = encodeImm8(opBeqz, 3'd2, 8'd2);
		rom[9]  = encodeImm5(opAddi, 3'd5, 3'd5, 5'd1);
		rom[10] = encodeImm8(opBnez, 3'd2, 8'd2);
		rom[11] = encodeImm8(opLbi, 3'd3, 8'(takeBits(8)) | 8'h01);
		rom[12] = encodeImm8(opBnez, 3'd3, 8'd2);
		rom[13] = encodeImm5(opAddi, 3'd4, 3'd4, 5'd3);
		// JAL to word 17, which reads the link right away
		rom[14] = encodeJump(opJal, 11'd4);
		rom[15] = encodeImm5(opAddi, 3'd6, 3'd6, 5'd7);
		rom[16] = encodeImm8(opLbi, 3'd6, 8'hff);
		rom[17] = encodeImm5(opAddi, 3'd7, 3'd1, 5'd0);
		rom[18] = encodeJump(opJ, 11'd2);
		rom[19] = encodeImm5(opAddi, 3'd2, 3'd2, 5'd1);
		// JR through a freshly loaded register to word 24
		rom[20] = encodeImm8(opLbi, 3'd4, 8'd40);
		rom[21] = encodeImm8(opJr, 3'd4, 8'd8);
		rom[22] = encodeImm5(opAddi, 3'd3, 3'd3, 5'd1);
		rom[24] = encodeImm5(opAddi, 3'd2, 3'd2, 5'(takeBits(5)));
		rom[26] = encodeAlu(3'd2, 3'd7, 3'd5, funcAdd);
		rom[27] = {opHalt, 11'd0};
		// behind the HALT, must never retire
		rom[28] = encodeImm5(opAddi, 3'd1, 3'd1, 5'd1);
	endtask

	// ISA model, fills the expected retire list, -1 if no HALT found
	function automatic int buildExpected();
		dataT   regs [8];
		pcT     pc;
		pcT     nextPc;
		instrT  w;
		opcodeT op;
		regIdxT rs;
		regIdxT dst;
		dataT   res;
		dataT   imm5;
		dataT   imm8;
		dataT   disp11;
		logic   wr;
		int     n;
		n  = 0;
		pc = '0;
		for (int i = 0; i < 8; i++) begin
			regs[i] = '0;
		end
		for (int step = 0; step < ModelSteps; step++) begin
			w      = rom[pc[6:1]];
			op     = w[15:11];
			rs     = w[10:8];
			imm5   = {{11{w[4]}}, w[4:0]};
			imm8   = {{8{w[7]}}, w[7:0]};
			disp11 = {{5{w[10]}}, w[10:0]};
			nextPc = pc + 16'd2;
			wr     = 1'b0;
			dst    = w[7:5];
			res    = '0;
			case (op)
				opHalt: return n;
				opAddi: begin
					wr  = 1'b1;
					res = regs[rs] + imm5;
				end
				opLbi: begin
					wr  = 1'b1;
					dst = rs;
					res = imm8;
				end
				opAlu: begin
					wr  = 1'b1;
					dst = w[4:2];
					case (w[1:0])
						2'b00: res = regs[rs] + regs[w[7:5]];
						2'b01: res = regs[rs] - regs[w[7:5]];
						2'b10: res = regs[rs] ^ regs[w[7:5]];
						default: res = regs[rs] & regs[w[7:5]];
					endcase
				end
				opJal: begin
					wr     = 1'b1;
					dst    = 3'd7;
					res    = pc + 16'd2;
					nextPc = pc + 16'd2 + disp11;
				end
				opJ: nextPc = pc + 16'd2 + disp11;
				opJr: nextPc = regs[rs] + imm8;
				opBeqz: if (regs[rs] == '0) nextPc = pc + 16'd2 + imm8;
				opBnez: if (regs[rs] != '0) nextPc = pc + 16'd2 + imm8;
				default: wr = 1'b0;
			endcase
			if (wr && n < MaxRetires) begin
				regs[dst]  = res;
				expReg[n]  = dst;
				expData[n] = res;
				expPc[n]   = pc;
				n++;
			end
			pc = nextPc;
		end
		return -1;
	endfunction

	task automatic endWithFailure();
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic failWith(input string why);
		$display("%s", why);
		endWithFailure();
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			endWithFailure();
		end
	endtask

	// credit return only for credits already used, odds of one in four
	always @(posedge clk) begin
		#1;
		creditPick   = takeBits(2);
		creditReturn = (outstanding > 0) && (creditPick[1:0] == 2'b11);
	end

	// retire checker, sampled mid-cycle
	always @(negedge clk) begin
		if (rstN) begin
			if (retireValid) begin
				if (halted) begin
					failWith("a register retired after halted rose");
				end else if (retireIdx >= expCount) begin
					failWith("more retires than the reference model expects");
				end else begin
					checkValue("retirePc", retirePc, expPc[retireIdx]);
					checkValue("retireReg", retireReg, expReg[retireIdx]);
					checkValue("retireData", retireData, expData[retireIdx]);
					retireIdx++;
				end
			end
			// credits held by the environment
			outstanding = outstanding + (retireValid ? 1 : 0) - (creditReturn ? 1 : 0);
			if (outstanding < 0 || outstanding > RetireCredits) begin
				failWith("outstanding retire credits left the allowed range");
			end
		end
	end

	initial begin
		rstN         = 1'b0;
		creditReturn = 1'b0;
		lfsr         = 32'h290c;
		retireIdx    = 0;
		outstanding  = 0;
		buildProgram();
		expCount = buildExpected();
		if (expCount < 0) begin
			failWith("reference model never reached HALT");
		end
		// outputs quiet through reset and the first cycle after
		for (int c = 0; c < 4; c++) begin
			@(posedge clk);
			#1;
			checkValue("retireValid", retireValid, 32'd0);
			checkValue("halted", halted, 32'd0);
		end
		rstN = 1'b1;
		@(posedge clk);
		@(negedge clk);
		checkValue("retireValid", retireValid, 32'd0);
		checkValue("halted", halted, 32'd0);
		for (waitCycles = 0; waitCycles < HaltTimeout && !halted; waitCycles++) begin
			@(negedge clk);
		end
		if (!halted) begin
			failWith("timeout while waiting for halted to rise");
		end
		// no retire and no fetch movement once halted
		haltAddr = imemAddr;
		repeat (QuietCycles) @(negedge clk);
		checkValue("imemAddr", imemAddr, haltAddr);
		checkValue("retireCount", retireIdx, expCount);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/cpuCore_assertions.sv
// **************************************************************************
// concurrent checks bound into the execute and fetch stages
// credit range, retire after halt, PC held while fetch is halted
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module cpuCoreAssertions #(
	parameter int RetireCredits = 4,
	// fetch checks instead of the execute checks
	parameter bit FetchSide     = 1'b0
) (
	input logic       clk,
	input logic       rstN,
	input logic       retireValid,
	input logic       halted,
	input logic       fetchHalted,
	input int         creditCount,
	input isaPkg::pcT imemAddr
);

	if (FetchSide) begin : fetchSide
		pcFrozen: assert property (@(posedge clk) disable iff (!rstN)
			fetchHalted |=> $stable(imemAddr))
			else $error("fetch address moved while halted");
	end else begin : execSide
		// counter never leaves the granted pool, an underflow wraps above it
		creditRange: assert property (@(posedge clk) disable iff (!rstN)
			creditCount <= RetireCredits)
			else $error("retire credit count out of range");

		noRetireAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
			halted |-> !retireValid)
			else $error("retire issued after halt");
	end

endmodule

// execute side, fetch ports tied off
bind executeStage cpuCoreAssertions #(
	.RetireCredits (RetireCredits),
	.FetchSide     (1'b0)
) execChecks (
	.clk         (clk),
	.rstN        (rstN),
	.retireValid (retireValid),
	.halted      (halted),
	.fetchHalted (1'b0),
	.creditCount (int'(credits)),
	.imemAddr    (16'h0000)
);

// fetch side, retire ports tied off
bind fetchStage cpuCoreAssertions #(
	.FetchSide (1'b1)
) fetchChecks (
	.clk         (clk),
	.rstN        (rstN),
	.retireValid (1'b0),
	.halted      (1'b0),
	.fetchHalted (state == pipePkg::fetchHalted),
	.creditCount (0),
	.imemAddr    (imemAddr)
);

`default_nettype wire

//--- hdl/cpuCore.sv
// **************************************************************************
// top level of the three-stage core
// external instruction memory in, retire stream with credit return out
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
	parameter int RetireCredits = 4
) (
	input  logic           clk,
	input  logic           rstN,
	input  isaPkg::instrT  imemData,
	input  logic           creditReturn,
	output isaPkg::pcT     imemAddr,
	output logic           retireValid,
	output isaPkg::regIdxT retireReg,
	output isaPkg::dataT   retireData,
	output isaPkg::pcT     retirePc,
	output logic           halted
);

	import isaPkg::*;

	// fetch to decode
	instrT fdInstr;
	pcT    fdPc;
	logic  fdValid;

	// decode back to fetch
	logic  redirect;
	pcT    target;
	logic  haltSeen;

	decodeExecIf deIf ();

	fetchStage fetch (
		.clk        (clk),
		.rstN       (rstN),
		.imemData   (imemData),
		.stall      (deIf.stall),
		.redirect   (redirect),
		.target     (target),
		.haltSeen   (haltSeen),
		.imemAddr   (imemAddr),
		.instr      (fdInstr),
		.pc         (fdPc),
		.instrValid (fdValid)
	);

	decodeStage decode (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (fdInstr),
		.pc         (fdPc),
		.instrValid (fdValid),
		.redirect   (redirect),
		.target     (target),
		.haltSeen   (haltSeen),
		.exec       (deIf.decode)
	);

	executeStage #(
		.RetireCredits (RetireCredits)
	) execute (
		.clk          (clk),
		.rstN         (rstN),
		.creditReturn (creditReturn),
		.dec          (deIf.execute),
		.retireValid  (retireValid),
		.retireReg    (retireReg),
		.retireData   (retireData),
		.retirePc     (retirePc),
		.halted       (halted)
	);

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
// **************************************************************************
// execute and writeback stage with the credit-controlled retire port
// a writer without credit holds here and stalls the whole pipeline
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module executeStage #(
	parameter int RetireCredits = 4
) (
	input  logic           clk,
	input  logic           rstN,
	input  logic           creditReturn,
	decodeExecIf.execute   dec,
	output logic           retireValid,
	output isaPkg::regIdxT retireReg,
	output isaPkg::dataT   retireData,
	output isaPkg::pcT     retirePc,
	output logic           halted
);

	import isaPkg::*;
	import pipePkg::*;

	localparam int CreditW = $clog2(RetireCredits + 1);

	typedef logic [CreditW-1:0] creditCntT;

	creditCntT credits;
	logic      exValid;
	ctrlT      exCtrl;
	dataT      exOpA;
	dataT      exOpB;
	regIdxT    exDest;
	pcT        exPc;
	dataT      aluResult;
	logic      wantsRetire;
	logic      stall;

	// decode to execute register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exValid <= 1'b0;
		end else if (!stall) begin
			exValid <= dec.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			exCtrl <= dec.ctrl;
			exOpA  <= dec.opA;
			exOpB  <= dec.opB;
			exDest <= dec.destReg;
			exPc   <= dec.pc;
		end
	end

	// ALU, sub is rs minus rt
	always_comb begin
		case (exCtrl.aluOp)
			aluPassA: aluResult = exOpA;
			aluAdd:   aluResult = exOpA + exOpB;
			aluSub:   aluResult = exOpA - exOpB;
			aluXor:   aluResult = exOpA ^ exOpB;
			aluAnd:   aluResult = exOpA & exOpB;
			default:  aluResult = '0;
		endcase
	end

	// every register write needs one credit
	assign wantsRetire = exValid && exCtrl.regWrite;
	assign stall       = wantsRetire && credits == '0;
	assign retireValid = wantsRetire && credits != '0;

	assign retireReg  = exDest;
	assign retireData = aluResult;
	assign retirePc   = exPc;

	// writeback and forwarding source for decode
	assign dec.wbEn   = retireValid;
	assign dec.wbReg  = exDest;
	assign dec.wbData = aluResult;
	assign dec.stall  = stall;

	// credit counter
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			credits <= creditCntT'(RetireCredits);
		end else begin
			case ({retireValid, creditReturn})
				2'b10:   credits <= credits - creditCntT'(1);
				2'b01:   credits <= credits + creditCntT'(1);
				default: credits <= credits;
			endcase
		end
	end

	// sticky, set as HALT leaves execute
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			halted <= 1'b0;
		end else if (exValid && exCtrl.isHalt && !stall) begin
			halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
// **************************************************************************
// decode stage, control decode and operand read for execute
// resolves branches and jumps here, redirecting fetch in the same cycle
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  logic          clk,
	input  logic          rstN,
	input  isaPkg::instrT instr,
	input  isaPkg::pcT    pc,
	input  logic          instrValid,
	output logic          redirect,
	output isaPkg::pcT    target,
	output logic          haltSeen,
	decodeExecIf.decode   exec
);

	import isaPkg::*;
	import pipePkg::*;

	opcodeT opcode;
	funcT   func;
	regIdxT rsSel;
	regIdxT rtSel;
	dataT   rsVal;
	dataT   rtVal;
	dataT   imm5Ext;
	dataT   imm8Ext;
	dataT   disp11Ext;
	pcT     pcNext;
	ctrlT   ctrl;
	regIdxT destReg;
	logic   taken;

	assign opcode = instr[opMsb:opLsb];
	assign func   = instr[funcMsb:funcLsb];
	assign rsSel  = instr[rsMsb:rsLsb];
	assign rtSel  = instr[rtMsb:rtLsb];

	// sign extended immediates of each format
	assign imm5Ext   = dataT'($signed(instr[imm5Msb:0]));
	assign imm8Ext   = dataT'($signed(instr[imm8Msb:0]));
	assign disp11Ext = dataT'($signed(instr[disp11Msb:0]));

	// branches and jumps are relative to the next sequential PC
	assign pcNext = pc + pcStep;

	// execute result drives the write port, its bypass forwards to both reads
	regFile rf (
		.clk     (clk),
		.rstN    (rstN),
		.rdSel1  (rsSel),
		.rdSel2  (rtSel),
		.wrEn    (exec.wbEn),
		.wrSel   (exec.wbReg),
		.wrData  (exec.wbData),
		.rdData1 (rsVal),
		.rdData2 (rtVal)
	);

	// control decode
	always_comb begin
		ctrl    = '0;
		// I-format rd sits in the rt slot
		destReg = rtSel;
		case (opcode)
			opHalt: begin
				ctrl.isHalt = 1'b1;
			end
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluAdd;
				ctrl.useImm   = 1'b1;
			end
			opLbi: begin
				// LBI loads into rs
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluPassA;
				destReg       = rsSel;
			end
			opAlu: begin
				ctrl.regWrite = 1'b1;
				destReg       = instr[rdMsb:rdLsb];
				case (func)
					funcAdd: ctrl.aluOp = aluAdd;
					funcSub: ctrl.aluOp = aluSub;
					funcXor: ctrl.aluOp = aluXor;
					funcAnd: ctrl.aluOp = aluAnd;
					default: ctrl.aluOp = aluAdd;
				endcase
			end
			opJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluPassA;
				destReg       = linkReg;
			end
			// NOP, branches, J, JR and unknown codes write nothing
			default: begin
				ctrl = '0;
			end
		endcase
	end

	// branch and jump resolution
	always_comb begin
		taken  = 1'b0;
		target = pcNext + imm8Ext;
		case (opcode)
			opBeqz: taken = (rsVal == '0);
			opBnez: taken = (rsVal != '0);
			opJ, opJal: begin
				taken  = 1'b1;
				target = pcNext + disp11Ext;
			end
			opJr: begin
				taken  = 1'b1;
				target = rsVal + imm8Ext;
			end
			default: taken = 1'b0;
		endcase
	end

	// only act when the pipeline moves
	assign redirect = instrValid && taken && !exec.stall;
	assign haltSeen = instrValid && opcode == opHalt && !exec.stall;

	// operand A is the link for JAL, the byte for LBI, else rs
	assign exec.opA     = (opcode == opJal) ? pcNext :
	                      (opcode == opLbi) ? imm8Ext : rsVal;
	assign exec.opB     = ctrl.useImm ? imm5Ext : rtVal;
	assign exec.valid   = instrValid;
	assign exec.ctrl    = ctrl;
	assign exec.destReg = destReg;
	assign exec.pc      = pc;

endmodule

`default_nettype wire

//--- hdl/fetchStage.sv
// **************************************************************************
// fetch stage, owns the PC and the instruction register
// steps by one word, follows decode redirects, stops after a HALT
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
	input  logic          clk,
	input  logic          rstN,
	input  isaPkg::instrT imemData,
	input  logic          stall,
	input  logic          redirect,
	input  isaPkg::pcT    target,
	input  logic          haltSeen,
	output isaPkg::pcT    imemAddr,
	output isaPkg::instrT instr,
	output isaPkg::pcT    pc,
	output logic          instrValid
);

	import isaPkg::*;
	import pipePkg::*;

	fetchStateT state;
	pcT         pcReg;

	// instruction memory reads combinationally at the PC
	assign imemAddr = pcReg;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state      <= fetchRun;
			pcReg      <= '0;
			instrValid <= 1'b0;
		end else if (!stall) begin
			if (redirect) begin
				// word fetched this cycle is wrong path, kill it
				pcReg      <= target;
				instrValid <= 1'b0;
			end else if (haltSeen || state == fetchHalted) begin
				// freeze the PC, issue only bubbles from now on
				state      <= fetchHalted;
				instrValid <= 1'b0;
			end else begin
				pcReg      <= pcReg + pcStep;
				instrValid <= 1'b1;
			end
		end
	end

	// payload only, qualified by instrValid
	always_ff @(posedge clk) begin
		if (!stall) begin
			instr <= imemData;
			pc    <= pcReg;
		end
	end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
// **************************************************************************
// eight 16-bit registers, two read ports and one write port
// a read of the register written this cycle sees the new value
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic           clk,
	input  logic           rstN,
	input  isaPkg::regIdxT rdSel1,
	input  isaPkg::regIdxT rdSel2,
	input  logic           wrEn,
	input  isaPkg::regIdxT wrSel,
	input  isaPkg::dataT   wrData,
	output isaPkg::dataT   rdData1,
	output isaPkg::dataT   rdData2
);

	import isaPkg::*;

	dataT regs [numRegs];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrSel] <= wrData;
		end
	end

	// write-to-read bypass
	assign rdData1 = (wrEn && wrSel == rdSel1) ? wrData : regs[rdSel1];
	assign rdData2 = (wrEn && wrSel == rdSel2) ? wrData : regs[rdSel2];

endmodule

`default_nettype wire

//--- hdl/decodeExecIf.sv
// **************************************************************************
// decode to execute link of the core pipeline
// operands and control go forward, writeback result and stall come back
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

interface decodeExecIf;

	import isaPkg::*;
	import pipePkg::*;

	// forward path, sampled by execute when not stalled
	logic   valid;
	ctrlT   ctrl;
	dataT   opA;
	dataT   opB;
	regIdxT destReg;
	pcT     pc;

	// result of the instruction now in execute, same cycle
	logic   wbEn;
	regIdxT wbReg;
	dataT   wbData;

	// execute holds a writer but has no retire credit
	logic   stall;

	modport decode (
		output valid,
		output ctrl,
		output opA,
		output opB,
		output destReg,
		output pc,
		input  wbEn,
		input  wbReg,
		input  wbData,
		input  stall
	);

	modport execute (
		input  valid,
		input  ctrl,
		input  opA,
		input  opB,
		input  destReg,
		input  pc,
		output wbEn,
		output wbReg,
		output wbData,
		output stall
	);

endinterface

`default_nettype wire

//--- hdl/pipePkg.sv
// **************************************************************************
// pipeline internals shared by the stages
// control bundle, ALU operation codes and fetch FSM states
// **************************************************************************
`default_nettype none

package pipePkg;

	// ALU operation select
	typedef logic [2:0] aluOpT;

	// passA forwards operand A untouched, used by LBI and the JAL link
	localparam aluOpT aluPassA = 3'd0;
	localparam aluOpT aluAdd   = 3'd1;
	localparam aluOpT aluSub   = 3'd2;
	localparam aluOpT aluXor   = 3'd3;
	localparam aluOpT aluAnd   = 3'd4;

	// control carried from decode into execute
	typedef struct packed {
		logic  regWrite;
		aluOpT aluOp;
		// operand B from the immediate instead of rt
		logic  useImm;
		logic  isHalt;
	} ctrlT;

	// fetch issues until a HALT is decoded
	typedef enum logic {
		fetchRun,
		fetchHalted
	} fetchStateT;

endpackage

`default_nettype wire

//--- hdl/isaPkg.sv
// **************************************************************************
// instruction set of the 16-bit eight-register core
// word and register widths, opcodes, ALU function codes, field positions
// **************************************************************************
`default_nettype none

package isaPkg;

	// architectural widths
	typedef logic [15:0] instrT;
	typedef logic [15:0] pcT;
	typedef logic [15:0] dataT;
	typedef logic [2:0]  regIdxT;
	typedef logic [4:0]  opcodeT;
	typedef logic [1:0]  funcT;

	localparam int numRegs = 8;

	// byte address, two bytes per instruction
	localparam pcT pcStep = 16'd2;

	// opcodes, top five bits of the word
	localparam opcodeT opHalt = 5'b00000;
	localparam opcodeT opNop  = 5'b00001;
	localparam opcodeT opJ    = 5'b00100;
	localparam opcodeT opJr   = 5'b00101;
	localparam opcodeT opJal  = 5'b00110;
	localparam opcodeT opAddi = 5'b01000;
	localparam opcodeT opBeqz = 5'b01100;
	localparam opcodeT opBnez = 5'b01101;
	localparam opcodeT opLbi  = 5'b11000;
	localparam opcodeT opAlu  = 5'b11011;

	// function field of opAlu
	localparam funcT funcAdd = 2'b00;
	localparam funcT funcSub = 2'b01;
	localparam funcT funcXor = 2'b10;
	localparam funcT funcAnd = 2'b11;

	// field positions, all immediates start at bit 0
	localparam int opMsb     = 15;
	localparam int opLsb     = 11;
	localparam int rsMsb     = 10;
	localparam int rsLsb     = 8;
	// rt in R-format, rd in I-format
	localparam int rtMsb     = 7;
	localparam int rtLsb     = 5;
	localparam int rdMsb     = 4;
	localparam int rdLsb     = 2;
	localparam int funcMsb   = 1;
	localparam int funcLsb   = 0;
	localparam int imm5Msb   = 4;
	localparam int imm8Msb   = 7;
	localparam int disp11Msb = 10;

	// JAL writes its return address here
	localparam regIdxT linkReg = 3'd7;

endpackage

`default_nettype wire
